// File: verilog/io_soc_pkg.sv
// Shared bus types, address-region and write-mode encodings, IO page layout
package io_soc_pkg;

  typedef logic [31:0] word_t;   // Bus address or data word
  typedef logic [3:0]  wmask_t;  // One bit per byte lane

  // Memory map from address bits 31:30
  typedef enum logic [1:0] {
    REGION_RAM   = 2'b00,  // Scratch RAM at 0x00000000
    REGION_IO    = 2'b01,  // One-hot IO page at 0x40000000
    REGION_FLASH = 2'b10,  // Unmapped, reads zero
    REGION_SDRAM = 2'b11   // Unmapped, reads zero
  } region_t;

  // IO write mode from address bits 3:2
  typedef enum logic [1:0] {
    IO_WRITE  = 2'b00,  // Plain store, +0
    IO_CLEAR  = 2'b01,  // Clear set bits, +4
    IO_SET    = 2'b10,  // OR in, +8
    IO_TOGGLE = 2'b11   // XOR in, +12
  } io_op_t;

  // One-hot select bits inside the IO page
  localparam int IO_PORTA_IN_BIT   = 4;   // R, pin readback
  localparam int IO_PORTA_OUT_BIT  = 5;   // RW, byte lanes
  localparam int IO_PORTA_DIR_BIT  = 6;   // RW, 1 is output
  localparam int IO_LEDS_BIT       = 7;   // RW
  localparam int IO_ANALOG_OUT_BIT = 15;  // RW, 3 x 4 bit DAC
  localparam int IO_TICKS_BIT      = 18;  // RW, timer count
  localparam int IO_RELOAD_BIT     = 19;  // RW, timer reload

  // Register widths
  localparam int LED_WIDTH       = 8;
  localparam int PORTA_PIN_WIDTH = 28;
  localparam int ANALOG_WIDTH    = 12;

endpackage

// File: verilog/region_decode.sv
`timescale 1ns/1ps
// Address region decode with one-cycle delayed region and read-data merge
module region_decode (
  input  logic              clk,
  input  io_soc_pkg::word_t mem_addr,
  input  io_soc_pkg::word_t ram_rdata,
  input  io_soc_pkg::word_t io_rdata,
  output logic              is_ram,
  output logic              is_io,
  output io_soc_pkg::word_t mem_rdata
);
  import io_soc_pkg::*;

  region_t region;    // Region of the current access
  region_t region_q;  // Region of last cycle's access

  // Top two bits pick the region
  assign region = region_t'(mem_addr[31:30]);

  // Strobe qualifiers for RAM and IO page
  assign is_ram = (region == REGION_RAM);
  assign is_io  = (region == REGION_IO);

  // Read data shows up one cycle after the strobe,
  // so the merge must follow the previous cycle's region
  always_ff @(posedge clk) begin
    region_q <= region;  // Updated every cycle
  end

  // OR of selects onto the bus
  always_comb begin
    mem_rdata = '0;
    if (region_q == REGION_RAM) begin
      mem_rdata = mem_rdata | ram_rdata;
    end
    if (region_q == REGION_IO) begin
      mem_rdata = mem_rdata | io_rdata;  // Buffered IO value
    end
    // Flash and SD-RAM regions leave it at zero
  end

endmodule

// File: verilog/scratch_ram.sv
`timescale 1ns/1ps
// Word-wide scratch RAM with byte write mask and registered read
module scratch_ram #(
  parameter int RAM_WORDS = 65536
) (
  input  logic               clk,
  input  logic               is_ram,
  input  io_soc_pkg::word_t  mem_addr,
  input  io_soc_pkg::word_t  mem_wdata,
  input  io_soc_pkg::wmask_t mem_wmask,
  output io_soc_pkg::word_t  ram_rdata
);
  import io_soc_pkg::*;

  localparam int IDX_W = $clog2(RAM_WORDS);  // Word index width

  word_t            mem [RAM_WORDS];  // Storage array
  logic [IDX_W-1:0] idx;              // Word index

  // Bits 1:0 are the byte offset
  assign idx = mem_addr[IDX_W+1:2];

  // Per-lane write enables
  always_ff @(posedge clk) begin
    for (int lane = 0; lane < 4; lane++) begin
      if (is_ram && mem_wmask[lane]) begin
        mem[idx][8*lane +: 8] <= mem_wdata[8*lane +: 8];
      end
    end
  end

  // Addressed word registered every cycle, whether strobed or not
  always_ff @(posedge clk) begin
    ram_rdata <= mem[idx];
  end

endmodule

// File: verilog/io_regs.sv
`timescale 1ns/1ps
// One-hot IO register page with write modes, port A byte lanes and buffered readback
module io_regs (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   is_io,
  input  io_soc_pkg::word_t                      mem_addr,
  input  io_soc_pkg::word_t                      mem_wdata,
  input  io_soc_pkg::wmask_t                     mem_wmask,
  input  logic                                   mem_rstrb,
  input  logic [io_soc_pkg::PORTA_PIN_WIDTH-1:0] porta_in,
  input  io_soc_pkg::word_t                      ticks,
  input  io_soc_pkg::word_t                      reload,
  output io_soc_pkg::word_t                      io_rdata,
  output logic [io_soc_pkg::LED_WIDTH-1:0]       led,
  output io_soc_pkg::word_t                      porta_out,
  output io_soc_pkg::word_t                      porta_dir,
  output logic [io_soc_pkg::ANALOG_WIDTH-1:0]    analog_out,
  output logic                                   ticks_we,
  output logic                                   reload_we
);
  import io_soc_pkg::*;

  logic   io_rstrb;  // Read strobe into the IO page
  logic   io_wstrb;  // Any-lane write into the IO page
  word_t  rd_mux;    // Current value of the selected register(s)
  word_t  io_mod;    // Write data after the write mode
  io_op_t op;        // Write mode

  assign io_rstrb = is_io & mem_rstrb;
  assign io_wstrb = is_io & (|mem_wmask);

  // OR of selects, one address bit per register
  always_comb begin
    rd_mux = '0;
    if (mem_addr[IO_PORTA_IN_BIT])   rd_mux = rd_mux | word_t'(porta_in);  // Zero-extended
    if (mem_addr[IO_PORTA_OUT_BIT])  rd_mux = rd_mux | porta_out;
    if (mem_addr[IO_PORTA_DIR_BIT])  rd_mux = rd_mux | porta_dir;
    if (mem_addr[IO_LEDS_BIT])       rd_mux = rd_mux | word_t'(led);
    if (mem_addr[IO_ANALOG_OUT_BIT]) rd_mux = rd_mux | word_t'(analog_out);
    if (mem_addr[IO_TICKS_BIT])      rd_mux = rd_mux | ticks;
    if (mem_addr[IO_RELOAD_BIT])     rd_mux = rd_mux | reload;
  end

  // Mode lives in address bits 3:2
  assign op = io_op_t'(mem_addr[3:2]);

  // Combine the bus data with the register's present value
  always_comb begin
    case (op)
      IO_CLEAR:  io_mod = rd_mux & ~mem_wdata;
      IO_SET:    io_mod = rd_mux | mem_wdata;
      IO_TOGGLE: io_mod = rd_mux ^ mem_wdata;
      default:   io_mod = mem_wdata;  // IO_WRITE
    endcase
  end

  // LEDs and analog out take any nonzero mask
  always_ff @(posedge clk) begin
    if (rst) begin
      led        <= '0;
      analog_out <= '0;
    end else begin
      if (io_wstrb && mem_addr[IO_LEDS_BIT]) begin
        led <= io_mod[LED_WIDTH-1:0];
      end
      if (io_wstrb && mem_addr[IO_ANALOG_OUT_BIT]) begin
        analog_out <= io_mod[ANALOG_WIDTH-1:0];
      end
    end
  end

  // Port A out and dir update lane by lane
  always_ff @(posedge clk) begin
    if (rst) begin
      porta_out <= '0;
      porta_dir <= '0;  // All pins start as inputs
    end else begin
      for (int lane = 0; lane < 4; lane++) begin
        if (is_io && mem_addr[IO_PORTA_OUT_BIT] && mem_wmask[lane]) begin
          porta_out[8*lane +: 8] <= io_mod[8*lane +: 8];
        end
        if (is_io && mem_addr[IO_PORTA_DIR_BIT] && mem_wmask[lane]) begin
          porta_dir[8*lane +: 8] <= io_mod[8*lane +: 8];
        end
      end
    end
  end

  // Timer registers take the raw bus word
  assign ticks_we  = io_wstrb & mem_addr[IO_TICKS_BIT];
  assign reload_we = io_wstrb & mem_addr[IO_RELOAD_BIT];

  // Snapshot at the strobe, held until the next IO read
  always_ff @(posedge clk) begin
    if (io_rstrb) begin
      io_rdata <= rd_mux;
    end
  end

  // Processor only issues byte, halfword or word stores
  a_wmask_legal: assert property (@(posedge clk) disable iff (rst)
    mem_wmask inside {4'b0000, 4'b0001, 4'b0010, 4'b0100,
                      4'b1000, 4'b0011, 4'b1100, 4'b1111});

  // Bus never reads and writes in one cycle
  a_no_rw_overlap: assert property (@(posedge clk) disable iff (rst)
    !(mem_rstrb && (mem_wmask != '0)));

endmodule

// File: verilog/tick_timer.sv
`timescale 1ns/1ps
// Free-running tick counter with reload on overflow and a one-cycle interrupt
module tick_timer (
  input  logic              clk,
  input  logic              rst,
  input  logic              ticks_we,
  input  logic              reload_we,
  input  io_soc_pkg::word_t mem_wdata,
  output io_soc_pkg::word_t ticks,
  output io_soc_pkg::word_t reload,
  output logic              irq
);
  import io_soc_pkg::*;

  logic [32:0] ticks_inc;   // Increment with carry out
  word_t       next_ticks;  // Value for the next cycle

  assign ticks_inc = {1'b0, ticks} + 33'd1;

  // Carry means ticks is all ones, so wrap to reload
  assign next_ticks = ticks_inc[32] ? reload : ticks_inc[31:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      ticks  <= '0;
      reload <= '0;
      irq    <= 1'b0;
    end else begin
      // Bus write wins over counting
      if (ticks_we) begin
        ticks <= mem_wdata;
      end else begin
        ticks <= next_ticks;
      end
      if (reload_we) begin
        reload <= mem_wdata;
      end
      irq <= ticks_inc[32];  // High the cycle after overflow
    end
  end

  // Interrupt is a single-cycle pulse
  a_irq_pulse: assert property (@(posedge clk) disable iff (rst)
    irq |=> !irq);

endmodule

// File: verilog/io_soc.sv
`timescale 1ns/1ps
// Memory-bus side of the system with region decode, scratch RAM, IO page and timer
module io_soc #(
  parameter int RAM_WORDS = 65536
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  io_soc_pkg::word_t                      mem_addr,
  input  io_soc_pkg::word_t                      mem_wdata,
  input  io_soc_pkg::wmask_t                     mem_wmask,
  input  logic                                   mem_rstrb,
  input  logic [io_soc_pkg::PORTA_PIN_WIDTH-1:0] porta_in,
  output io_soc_pkg::word_t                      mem_rdata,
  output logic [io_soc_pkg::LED_WIDTH-1:0]       led,
  output io_soc_pkg::word_t                      porta_out,
  output io_soc_pkg::word_t                      porta_dir,
  output logic [io_soc_pkg::ANALOG_WIDTH-1:0]    analog_out,
  output logic                                   irq
);
  import io_soc_pkg::*;

  logic  is_ram;     // Access targets RAM
  logic  is_io;      // Access targets IO page
  word_t ram_rdata;  // Registered RAM word
  word_t io_rdata;   // Buffered IO word
  word_t ticks;
  word_t reload;
  logic  ticks_we;
  logic  reload_we;

  region_decode i_region_decode (
    .clk       (clk),
    .mem_addr  (mem_addr),
    .ram_rdata (ram_rdata),
    .io_rdata  (io_rdata),
    .is_ram    (is_ram),
    .is_io     (is_io),
    .mem_rdata (mem_rdata)
  );

  scratch_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) i_scratch_ram (
    .clk       (clk),
    .is_ram    (is_ram),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .ram_rdata (ram_rdata)
  );

  io_regs i_io_regs (
    .clk        (clk),
    .rst        (rst),
    .is_io      (is_io),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wmask  (mem_wmask),
    .mem_rstrb  (mem_rstrb),
    .porta_in   (porta_in),
    .ticks      (ticks),
    .reload     (reload),
    .io_rdata   (io_rdata),
    .led        (led),
    .porta_out  (porta_out),
    .porta_dir  (porta_dir),
    .analog_out (analog_out),
    .ticks_we   (ticks_we),
    .reload_we  (reload_we)
  );

  // Timer sees raw bus data, no write mode
  tick_timer i_tick_timer (
    .clk       (clk),
    .rst       (rst),
    .ticks_we  (ticks_we),
    .reload_we (reload_we),
    .mem_wdata (mem_wdata),
    .ticks     (ticks),
    .reload    (reload),
    .irq       (irq)
  );

endmodule

// File: verification/io_soc_tb.sv
`timescale 1ns/1ps
// Testbench for the memory-bus system, drives the bus as the processor would
module io_soc_tb;
  import io_soc_pkg::*;

  localparam int    RAM_WORDS = 1024;
  localparam int    TIMEOUT   = 4000;          // About twice the stimulus length
  localparam word_t IO_BASE   = 32'h4000_0000;

  logic                       clk = 1'b0;
  logic                       rst;
  word_t                      mem_addr;
  word_t                      mem_wdata;
  wmask_t                     mem_wmask;
  logic                       mem_rstrb;
  logic [PORTA_PIN_WIDTH-1:0] porta_in;
  word_t                      mem_rdata;
  logic [LED_WIDTH-1:0]       led;
  word_t                      porta_out;
  word_t                      porta_dir;
  logic [ANALOG_WIDTH-1:0]    analog_out;
  logic                       irq;

  // Reference model state
  word_t                   ram_m [RAM_WORDS];
  logic [LED_WIDTH-1:0]    led_m;
  word_t                   porta_out_m;
  word_t                   porta_dir_m;
  logic [ANALOG_WIDTH-1:0] analog_m;
  word_t                   reload_m;
  word_t                   tick_base;         // Ticks value in the cycle at tick_mark
  logic [63:0]             tick_mark;
  logic [63:0]             ticks_left;        // Increments until all ones
  logic                    exp_irq;

  logic [63:0] cyc = '0;    // Edges seen so far
  word_t       rd_exp;      // Expected data for the current strobe
  word_t       rd_exp_q = '0;
  logic        rd_due = 1'b0;  // Read data due this cycle

  io_soc #(
    .RAM_WORDS (RAM_WORDS)
  ) i_io_soc (
    .clk        (clk),
    .rst        (rst),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wmask  (mem_wmask),
    .mem_rstrb  (mem_rstrb),
    .porta_in   (porta_in),
    .mem_rdata  (mem_rdata),
    .led        (led),
    .porta_out  (porta_out),
    .porta_dir  (porta_dir),
    .analog_out (analog_out),
    .irq        (irq)
  );

  always #2 clk = ~clk;  // 4 ns period

  // Cycle count and run limit
  always @(posedge clk) begin
    cyc <= cyc + 64'd1;
    if (cyc == TIMEOUT) begin
      $display("Run timed out after %0d cycles without finishing the tests", cyc);
      $display("Test FAILED");
      $fatal(1, "timeout");
    end
  end

  // Read data belongs to the cycle after the strobe
  always @(posedge clk) begin
    rd_due   <= mem_rstrb;
    rd_exp_q <= rd_exp;
  end

  // Overflow comes one edge after ticks is all ones
  assign ticks_left = 64'hFFFF_FFFF - {32'h0, tick_base};
  assign exp_irq    = ((cyc - tick_mark) == ticks_left + 64'd1);

  task automatic report_mismatch(string name, word_t exp, word_t act);
    $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    $display("Test FAILED");
    $fatal(1, "value mismatch");
  endtask

  a_rdata: assert property (@(posedge clk) disable iff (rst) rd_due |-> mem_rdata == rd_exp_q)
    else report_mismatch("mem_rdata", $sampled(rd_exp_q), $sampled(mem_rdata));
  a_led: assert property (@(posedge clk) disable iff (rst) led == led_m)
    else report_mismatch("led", word_t'($sampled(led_m)), word_t'($sampled(led)));
  a_porta_out: assert property (@(posedge clk) disable iff (rst) porta_out == porta_out_m)
    else report_mismatch("porta_out", $sampled(porta_out_m), $sampled(porta_out));
  a_porta_dir: assert property (@(posedge clk) disable iff (rst) porta_dir == porta_dir_m)
    else report_mismatch("porta_dir", $sampled(porta_dir_m), $sampled(porta_dir));
  a_analog: assert property (@(posedge clk) disable iff (rst) analog_out == analog_m)
    else report_mismatch("analog_out", word_t'($sampled(analog_m)),
                         word_t'($sampled(analog_out)));
  a_irq: assert property (@(posedge clk) disable iff (rst) irq == exp_irq)
    else report_mismatch("irq", word_t'($sampled(exp_irq)), word_t'($sampled(irq)));

  // IO page address for one register and write mode
  function automatic word_t io_addr(int bit_pos, io_op_t op);
    return IO_BASE | (word_t'(1) << bit_pos) | (word_t'(op) << 2);
  endfunction

  // Distinct per word, spans the whole index
  function automatic word_t fill_word(int idx);
    return (word_t'(idx) * 32'h9E37_79B9) ^ 32'h0F1E_2D3C;
  endfunction

  // Byte, halfword or word store masks only
  function automatic wmask_t pick_mask();
    case ($urandom_range(6, 0))
      0:       return 4'b0001;
      1:       return 4'b0010;
      2:       return 4'b0100;
      3:       return 4'b1000;
      4:       return 4'b0011;
      5:       return 4'b1100;
      default: return 4'b1111;
    endcase
  endfunction

  // Counts up from the last write, wraps once to reload
  function automatic word_t model_ticks();
    logic [63:0] n;
    n = cyc - tick_mark;
    if (n <= ticks_left) begin
      return tick_base + n[31:0];
    end else begin
      return reload_m + n[31:0] - ticks_left[31:0] - 32'd1;
    end
  endfunction

  // OR of all selected registers in the IO page
  function automatic word_t io_model_read(word_t addr);
    word_t v;
    v = '0;
    if (addr[IO_PORTA_IN_BIT])   v = v | word_t'(porta_in);
    if (addr[IO_PORTA_OUT_BIT])  v = v | porta_out_m;
    if (addr[IO_PORTA_DIR_BIT])  v = v | porta_dir_m;
    if (addr[IO_LEDS_BIT])       v = v | word_t'(led_m);
    if (addr[IO_ANALOG_OUT_BIT]) v = v | word_t'(analog_m);
    if (addr[IO_TICKS_BIT])      v = v | model_ticks();
    if (addr[IO_RELOAD_BIT])     v = v | reload_m;
    return v;
  endfunction

  function automatic word_t expected_read(word_t addr);
    if (addr[31:30] == REGION_RAM) return ram_m[addr[11:2]];
    if (addr[31:30] == REGION_IO) return io_model_read(addr);
    return '0;  // Flash and SD-RAM unmapped
  endfunction

  // Model update for one bus write, cur is the value before the edge
  task automatic apply_write(word_t addr, word_t data, wmask_t mask, word_t cur);
    word_t mod;
    case (io_op_t'(addr[3:2]))
      IO_CLEAR:  mod = cur & ~data;
      IO_SET:    mod = cur | data;
      IO_TOGGLE: mod = cur ^ data;
      default:   mod = data;
    endcase
    if (addr[31:30] == REGION_RAM) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (mask[lane]) ram_m[addr[11:2]][8*lane +: 8] = data[8*lane +: 8];
      end
    end else if (addr[31:30] == REGION_IO && mask != '0) begin
      if (addr[IO_LEDS_BIT])       led_m    = mod[LED_WIDTH-1:0];
      if (addr[IO_ANALOG_OUT_BIT]) analog_m = mod[ANALOG_WIDTH-1:0];
      for (int lane = 0; lane < 4; lane++) begin
        if (addr[IO_PORTA_OUT_BIT] && mask[lane]) porta_out_m[8*lane +: 8] = mod[8*lane +: 8];
        if (addr[IO_PORTA_DIR_BIT] && mask[lane]) porta_dir_m[8*lane +: 8] = mod[8*lane +: 8];
      end
      if (addr[IO_TICKS_BIT]) begin
        tick_base = data;  // Raw data, write mode ignored
        tick_mark = cyc;   // First cycle holding the new value
      end
      if (addr[IO_RELOAD_BIT]) reload_m = data;
    end
  endtask

  // Called and returns 1 ns after a rising edge
  task automatic bus_write(word_t addr, word_t data, wmask_t mask);
    word_t cur;
    cur       = io_model_read(addr);
    mem_addr  = addr;
    mem_wdata = data;
    mem_wmask = mask;
    @(posedge clk);
    #1;
    mem_wmask = '0;
    apply_write(addr, data, mask, cur);
  endtask

  task automatic bus_read(word_t addr);
    rd_exp    = expected_read(addr);
    mem_addr  = addr;
    mem_rstrb = 1'b1;
    @(posedge clk);
    #1;
    mem_rstrb = 1'b0;
  endtask

  task automatic check_reset_reads();
    bus_read(io_addr(IO_LEDS_BIT, IO_WRITE));
    bus_read(io_addr(IO_PORTA_OUT_BIT, IO_WRITE));
    bus_read(io_addr(IO_PORTA_DIR_BIT, IO_WRITE));
    bus_read(io_addr(IO_ANALOG_OUT_BIT, IO_WRITE));
    bus_read(io_addr(IO_RELOAD_BIT, IO_WRITE));
    bus_read(io_addr(IO_PORTA_IN_BIT, IO_WRITE));
  endtask

  task automatic ram_readback();
    word_t addr;
    for (int i = 0; i < RAM_WORDS; i++) bus_write(word_t'(i) << 2, fill_word(i), 4'b1111);
    for (int i = 0; i < 250; i++) begin
      addr = word_t'($urandom_range(RAM_WORDS - 1, 0)) << 2;
      bus_write(addr, $urandom(), pick_mask());
      bus_read(word_t'($urandom_range(RAM_WORDS - 1, 0)) << 2);  // Some other word
      bus_read(addr);
    end
  endtask

  task automatic io_write_modes();
    io_op_t op;
    for (int i = 0; i < 24; i++) begin
      op = io_op_t'(2'(i));  // Cycle through all four modes
      bus_write(io_addr(IO_LEDS_BIT, op), $urandom(), pick_mask());
      bus_read(io_addr(IO_LEDS_BIT, IO_WRITE));
      bus_write(io_addr(IO_ANALOG_OUT_BIT, op), $urandom(), pick_mask());
      bus_read(io_addr(IO_ANALOG_OUT_BIT, op));
    end
  endtask

  task automatic porta_access();
    io_op_t op;
    porta_in = PORTA_PIN_WIDTH'($urandom());
    bus_read(io_addr(IO_PORTA_IN_BIT, IO_WRITE));
    for (int i = 0; i < 32; i++) begin
      op = io_op_t'(2'($urandom_range(3, 0)));
      bus_write(io_addr(IO_PORTA_OUT_BIT, op), $urandom(), pick_mask());
      bus_read(io_addr(IO_PORTA_OUT_BIT, IO_WRITE));
      bus_write(io_addr(IO_PORTA_DIR_BIT, op), $urandom(), pick_mask());
      bus_read(io_addr(IO_PORTA_DIR_BIT, IO_WRITE));
    end
    porta_in = PORTA_PIN_WIDTH'($urandom());
    bus_read(io_addr(IO_PORTA_IN_BIT, IO_SET));
  endtask

  task automatic timer_overflow();
    word_t reload_val;
    int    k;
    reload_val = $urandom() & 32'h7FFF_FFFF;  // Far from all ones, no second wrap
    bus_write(io_addr(IO_RELOAD_BIT, IO_WRITE), reload_val, 4'b1111);
    bus_read(io_addr(IO_RELOAD_BIT, IO_WRITE));
    bus_write(io_addr(IO_TICKS_BIT, IO_WRITE), 32'hFFFF_FFFF - 32'd10, 4'b1111);
    repeat (11) @(posedge clk);  // a_irq watches the pulse
    #1;
    k = $urandom_range(5, 0);
    repeat (k + 1) @(posedge clk);
    #1;
    bus_read(io_addr(IO_TICKS_BIT, IO_WRITE));  // reload + k + 1
    bus_read(io_addr(IO_RELOAD_BIT, IO_WRITE));
    bus_read(io_addr(IO_TICKS_BIT, IO_WRITE));
  endtask

  task automatic unmapped_access();
    word_t off;
    off = word_t'($urandom_range(RAM_WORDS - 1, 0)) << 2;
    bus_write(32'h8000_0000 | off, $urandom(), 4'b1111);
    bus_write(32'hC000_0000 | off, $urandom(), 4'b1111);
    bus_write(32'h8000_0000 | io_addr(IO_LEDS_BIT, IO_WRITE), $urandom(), 4'b1111);
    bus_write(32'h8000_0000 | io_addr(IO_PORTA_OUT_BIT, IO_SET), $urandom(), 4'b1111);
    bus_write(32'h8000_0000 | io_addr(IO_TICKS_BIT, IO_WRITE), $urandom(), 4'b1111);
    bus_read(32'h8000_0000 | off);
    bus_read(32'hC000_0000 | off);
    bus_read(32'h8000_0000 | io_addr(IO_LEDS_BIT, IO_WRITE));
    bus_read(off);  // RAM word untouched
    bus_read(io_addr(IO_LEDS_BIT, IO_WRITE));
    bus_read(io_addr(IO_PORTA_OUT_BIT, IO_WRITE));
    bus_read(io_addr(IO_TICKS_BIT, IO_WRITE));
  endtask

  initial begin
    void'($urandom(90667));
    rst         = 1'b1;
    mem_addr    = '0;
    mem_wdata   = '0;
    mem_wmask   = '0;
    mem_rstrb   = 1'b0;
    porta_in    = '0;
    rd_exp      = '0;
    led_m       = '0;
    porta_out_m = '0;
    porta_dir_m = '0;
    analog_m    = '0;
    reload_m    = '0;
    tick_base   = '0;
    tick_mark   = '0;
    repeat (4) @(posedge clk);
    #1;
    rst       = 1'b0;
    tick_mark = cyc;  // Ticks is zero in this cycle
    check_reset_reads();
    ram_readback();
    io_write_modes();
    porta_access();
    timer_overflow();
    unmapped_access();
    repeat (2) @(posedge clk);  // Last read check
    #1;
    $display("Test OK");
    $finish;
  end

endmodule

// File: io_soc.f
verilog/io_soc_pkg.sv
verilog/region_decode.sv
verilog/scratch_ram.sv
verilog/io_regs.sv
verilog/tick_timer.sv
verilog/io_soc.sv
verification/io_soc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the io_soc testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f io_soc.f \
  --top-module io_soc_tb

# A failing run exits nonzero, the search below decides the result
sim_output=$(./obj_dir/Vio_soc_tb 2>&1 || true)
echo "$sim_output"

if grep -qx "Test OK" <<< "$sim_output"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation did not pass"
  exit 1
fi
